// ==== Bender.yml ====
package:
  name: spi_memory

export_include_dirs:
  - logic

sources:
  # the package comes first, the modules use its types.
  - include_dirs:
      - logic
    files:
      - logic/spiMemPkg.sv
      - logic/inputConditioner.sv
      - logic/spiFsm.sv
      - logic/shiftRegister.sv
      - logic/dataMemory.sv
      - logic/spiMemory.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/spiMemoryTb.sv

// ==== logic/dataMemory.sv ====
`timescale 1ns/1ps
`include "spiMem_consts.svh"

module dataMemory (
  input  logic clk,
  input  logic addressWriteEnable,
  input  logic dmWriteEnable,
  input  spiMemPkg::spiAddr addrIn,
  input  spiMemPkg::spiByte dataIn,
  output spiMemPkg::spiByte dataOut
);

  import spiMemPkg::*;

  spiAddr addrLatch;
  spiByte memArray [`SPI_MEM_DEPTH];

  always_ff @(posedge clk) begin
    if (addressWriteEnable) begin
      addrLatch <= addrIn;
    end
  end

  always_ff @(posedge clk) begin
    if (dmWriteEnable) begin
      memArray[addrLatch] <= dataIn;
    end
  end

  // read runs every clock, so data is ready one clock after the latch.
  always_ff @(posedge clk) begin
    dataOut <= memArray[addrLatch];
  end

endmodule

// ==== logic/inputConditioner.sv ====
`timescale 1ns/1ps
`include "spiMem_consts.svh"

module inputConditioner (
  input  logic clk,
  input  logic rstN,
  input  logic csN,
  input  logic sclk,
  input  logic mosi,
  output logic csCond,
  output logic mosiCond,
  output logic sclkRise,
  output logic sclkFall
);

  localparam int FilterCycles = `SPI_FILTER_CYCLES;
  localparam int CntWidth = $clog2(FilterCycles + 1);
  localparam int NumPins = 3;
  localparam int CsIdx = 2;
  localparam int SclkIdx = 1;
  localparam int MosiIdx = 0;
  // chip select idles high, the others idle low.
  localparam logic [NumPins-1:0] IdleLevels = 3'b100;

  logic [NumPins-1:0] rawPins;
  logic [NumPins-1:0] syncStage1;
  logic [NumPins-1:0] syncStage2;
  logic [NumPins-1:0] condLevel;
  logic [CntWidth-1:0] stableCnt [NumPins];
  logic sclkPrev;

  assign rawPins = {csN, sclk, mosi};

  for (genvar i = 0; i < NumPins; i++) begin : gPin
    always_ff @(posedge clk) begin
      if (!rstN) begin
        syncStage1[i] <= IdleLevels[i];
        syncStage2[i] <= IdleLevels[i];
        condLevel[i] <= IdleLevels[i];
        stableCnt[i] <= '0;
      end else begin
        syncStage1[i] <= rawPins[i];
        syncStage2[i] <= syncStage1[i];
        // a new level must survive the whole count before it is taken.
        if (syncStage2[i] == condLevel[i]) begin
          stableCnt[i] <= '0;
        end else if (stableCnt[i] == CntWidth'(FilterCycles)) begin
          condLevel[i] <= syncStage2[i];
          stableCnt[i] <= '0;
        end else begin
          stableCnt[i] <= stableCnt[i] + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      sclkPrev <= 1'b0;
    end else begin
      sclkPrev <= condLevel[SclkIdx];
    end
  end

  assign csCond = condLevel[CsIdx];
  assign mosiCond = condLevel[MosiIdx];
  // pulses line up with the clock in which the filtered sclk changes.
  assign sclkRise = condLevel[SclkIdx] & ~sclkPrev;
  assign sclkFall = ~condLevel[SclkIdx] & sclkPrev;

endmodule

// ==== logic/shiftRegister.sv ====
`timescale 1ns/1ps
`include "spiMem_consts.svh"

module shiftRegister (
  input  logic clk,
  input  logic rstN,
  input  logic sclkRise,
  input  logic sclkFall,
  input  logic serialIn,
  input  logic srLoad,
  input  spiMemPkg::spiByte parallelIn,
  output spiMemPkg::spiByte parallelOut,
  output logic misoBit
);

  import spiMemPkg::*;

  spiByte shiftData;

  // load wins over a shift in the same clock.
  always_ff @(posedge clk) begin
    if (srLoad) begin
      shiftData <= parallelIn;
    end else if (sclkRise) begin
      shiftData <= {shiftData[`SPI_DATA_BITS-2:0], serialIn};
    end
  end

  // the msb goes out on falling edges so it is stable at the next rise.
  always_ff @(posedge clk) begin
    if (!rstN) begin
      misoBit <= 1'b0;
    end else if (sclkFall) begin
      misoBit <= shiftData[`SPI_DATA_BITS-1];
    end
  end

  assign parallelOut = shiftData;

endmodule

// ==== logic/spiFsm.sv ====
`timescale 1ns/1ps
`include "spiMem_consts.svh"

module spiFsm (
  input  logic clk,
  input  logic rstN,
  input  logic sclkRise,
  input  logic csCond,
  input  logic readWriteBit,
  output logic misoBufferEnable,
  output logic dmWriteEnable,
  output logic addressWriteEnable,
  output logic srLoad
);

  import spiMemPkg::*;

  spiState state;
  logic [3:0] bitCnt;
  logic [3:0] bitCntNext;
  logic countingState;
  logic fieldDone;

  assign countingState = (state == stateGet) || (state == stateRead3) ||
                         (state == stateWrite1);
  assign bitCntNext = bitCnt + 4'd1;
  // true on the rising edge that completes the current field.
  assign fieldDone = sclkRise && (bitCntNext == 4'(`SPI_DATA_BITS));

  // bit counter, restarted at each field boundary.
  always_ff @(posedge clk) begin
    if (!rstN || csCond) begin
      bitCnt <= '0;
    end else if (countingState && sclkRise) begin
      if (fieldDone) begin
        bitCnt <= '0;
      end else begin
        bitCnt <= bitCntNext;
      end
    end
  end

  // chip select high always drops back to waiting for a command.
  always_ff @(posedge clk) begin
    if (!rstN || csCond) begin
      state <= stateGet;
    end else begin
      case (state)
        stateGet: begin
          if (fieldDone) begin
            state <= stateGot;
          end
        end
        stateGot: begin
          if (readWriteBit) begin
            state <= stateRead1;
          end else begin
            state <= stateWrite1;
          end
        end
        stateRead1: begin
          state <= stateRead2;
        end
        stateRead2: begin
          state <= stateRead3;
        end
        stateRead3: begin
          if (fieldDone) begin
            state <= stateDone;
          end
        end
        stateWrite1: begin
          if (fieldDone) begin
            state <= stateWrite2;
          end
        end
        stateWrite2: begin
          state <= stateDone;
        end
        stateDone: begin
          state <= stateDone;
        end
        default: begin
          state <= stateGet;
        end
      endcase
    end
  end

  assign addressWriteEnable = (state == stateGot);
  assign srLoad = (state == stateRead2);
  assign misoBufferEnable = (state == stateRead3);
  assign dmWriteEnable = (state == stateWrite2);

endmodule

// ==== logic/spiMemPkg.sv ====
`include "spiMem_consts.svh"

package spiMemPkg;

  // memory address taken from the upper bits of the command field.
  typedef logic [`SPI_ADDR_BITS-1:0] spiAddr;

  // one data byte, also the width of the serial shift register.
  typedef logic [`SPI_DATA_BITS-1:0] spiByte;

  // transaction controller states.
  typedef enum logic [2:0] {
    stateGet,
    stateGot,
    stateRead1,
    stateRead2,
    stateRead3,
    stateWrite1,
    stateWrite2,
    stateDone
  } spiState;

endpackage

// ==== logic/spiMem_consts.svh ====
`ifndef SPI_MEM_CONSTS_SVH
`define SPI_MEM_CONSTS_SVH

// width of the address part of the command field.
`define SPI_ADDR_BITS 7

// bits per field, also the data byte width.
`define SPI_DATA_BITS 8

// number of bytes in the memory array.
`define SPI_MEM_DEPTH 128

// clocks a synchronized pin must hold a new level before it is accepted.
`define SPI_FILTER_CYCLES 2

`endif

// ==== logic/spiMemory.sv ====
`timescale 1ns/1ps
`include "spiMem_consts.svh"

module spiMemory (
  input  logic clk,
  input  logic rstN,
  input  logic csN,
  input  logic sclk,
  input  logic mosi,
  output logic miso,
  output logic misoBufferEnable
);

  logic csCond;
  logic mosiCond;
  logic sclkRise;
  logic sclkFall;
  logic dmWriteEnable;
  logic addressWriteEnable;
  logic srLoad;
  logic readWriteBit;
  spiMemPkg::spiAddr memAddr;
  spiMemPkg::spiByte parallelData;
  spiMemPkg::spiByte memData;

  // command field is address in the upper bits, read flag in bit 0.
  assign memAddr = parallelData[`SPI_DATA_BITS-1:1];
  assign readWriteBit = parallelData[0];

  inputConditioner inputConditioner_i (
    .clk      (clk),
    .rstN     (rstN),
    .csN      (csN),
    .sclk     (sclk),
    .mosi     (mosi),
    .csCond   (csCond),
    .mosiCond (mosiCond),
    .sclkRise (sclkRise),
    .sclkFall (sclkFall)
  );

  spiFsm spiFsm_i (
    .clk                (clk),
    .rstN               (rstN),
    .sclkRise           (sclkRise),
    .csCond             (csCond),
    .readWriteBit       (readWriteBit),
    .misoBufferEnable   (misoBufferEnable),
    .dmWriteEnable      (dmWriteEnable),
    .addressWriteEnable (addressWriteEnable),
    .srLoad             (srLoad)
  );

  shiftRegister shiftRegister_i (
    .clk         (clk),
    .rstN        (rstN),
    .sclkRise    (sclkRise),
    .sclkFall    (sclkFall),
    .serialIn    (mosiCond),
    .srLoad      (srLoad),
    .parallelIn  (memData),
    .parallelOut (parallelData),
    .misoBit     (miso)
  );

  dataMemory dataMemory_i (
    .clk                (clk),
    .addressWriteEnable (addressWriteEnable),
    .dmWriteEnable      (dmWriteEnable),
    .addrIn             (memAddr),
    .dataIn             (parallelData),
    .dataOut            (memData)
  );

endmodule

// ==== sim/spiMemoryTb.sv ====
`timescale 1ns/1ps
`include "spiMem_consts.svh"

module spiMemoryTb;

  localparam int HalfPeriod = 8;
  localparam int TimeoutCycles = 20000;
  localparam int ByteBits = `SPI_DATA_BITS;
  localparam int FrameBits = 2 * `SPI_DATA_BITS;
  localparam int NoGlitch = -1;

  logic clk;
  logic rstN;
  logic csN;
  logic sclk;
  logic mosi;
  logic miso;
  logic misoBufferEnable;

  // expected memory contents, updated by every completed write.
  logic [ByteBits-1:0] model [`SPI_MEM_DEPTH];
  int errorCount;
  int testCount;
  int failedTests;
  int cycleCount;
  logic enableAfterReset;

  spiMemory dut_i (
    .clk              (clk),
    .rstN             (rstN),
    .csN              (csN),
    .sclk             (sclk),
    .mosi             (mosi),
    .miso             (miso),
    .misoBufferEnable (misoBufferEnable)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  initial begin
    cycleCount = 0;
    while (cycleCount < TimeoutCycles) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("the run timed out after %0d clock cycles without finishing", cycleCount);
    $display("tests failed");
    $finish;
  end

  task automatic waitClocks(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic checkByte(input string what, input logic [ByteBits-1:0] got,
                           input logic [ByteBits-1:0] expected);
    assert (got === expected)
    else begin
      $display("ERROR at %0t ns: %s read %h, expected %h", $time, what, got, expected);
      errorCount++;
    end
  endtask

  task automatic checkEnable(input logic expected, input string where);
    assert (misoBufferEnable === expected)
    else begin
      $display("ERROR at %0t ns: misoBufferEnable is %b %s, expected %b",
               $time, misoBufferEnable, where, expected);
      errorCount++;
    end
  endtask

  // mode 0 master. mosi changes while sclk is low, miso is taken before each rise.
  task automatic runFrame(input logic [FrameBits-1:0] frame, input int numBits,
                          input bit isRead, input int glitchAt,
                          output logic [ByteBits-1:0] captured);
    logic expectEnable;
    captured = '0;
    csN = 1'b0;
    for (int i = 0; i < numBits; i++) begin
      mosi = frame[FrameBits-1-i];
      if (i == glitchAt) begin
        // single clock spike on sclk in the middle of the low phase.
        waitClocks(3);
        sclk = 1'b1;
        waitClocks(1);
        sclk = 1'b0;
        waitClocks(HalfPeriod - 4);
      end else begin
        waitClocks(HalfPeriod);
      end
      expectEnable = isRead && (i >= ByteBits);
      checkEnable(expectEnable, "before a rising sclk");
      if (i >= ByteBits) begin
        captured[FrameBits-1-i] = miso;
      end
      sclk = 1'b1;
      waitClocks(HalfPeriod);
      sclk = 1'b0;
    end
    mosi = 1'b0;
    waitClocks(HalfPeriod);
    csN = 1'b1;
    waitClocks(4 * HalfPeriod);
    checkEnable(1'b0, "with chip select high");
  endtask

  task automatic spiWrite(input logic [`SPI_ADDR_BITS-1:0] addr,
                          input logic [ByteBits-1:0] data);
    logic [ByteBits-1:0] unused;
    runFrame({addr, 1'b0, data}, FrameBits, 1'b0, NoGlitch, unused);
    model[addr] = data;
  endtask

  task automatic spiRead(input logic [`SPI_ADDR_BITS-1:0] addr,
                         output logic [ByteBits-1:0] data);
    runFrame({addr, 1'b1, {ByteBits{1'b0}}}, FrameBits, 1'b1, NoGlitch, data);
  endtask

  task automatic readAndCompare(input logic [`SPI_ADDR_BITS-1:0] addr);
    logic [ByteBits-1:0] got;
    spiRead(addr, got);
    checkByte($sformatf("address %0d", addr), got, model[addr]);
  endtask

  task automatic reportTest(input string name, input int errorsBefore);
    testCount++;
    if (errorCount == errorsBefore) begin
      $display("%s: PASS", name);
    end else begin
      $display("%s: FAIL with %0d errors", name, errorCount - errorsBefore);
      failedTests++;
    end
  endtask

  task automatic testWriteReadBack();
    int errorsBefore;
    logic [ByteBits-1:0] got;
    errorsBefore = errorCount;
    spiWrite(7'd5, 8'hA5);
    spiRead(7'd5, got);
    checkByte("address 5", got, 8'hA5);
    reportTest("writeReadBack", errorsBefore);
  endtask

  task automatic testRandomStress();
    int errorsBefore;
    logic [`SPI_ADDR_BITS-1:0] addrs [16];
    errorsBefore = errorCount;
    for (int i = 0; i < 16; i++) begin
      // the last write reuses an earlier address so an overwrite is always read back.
      if (i == 15) begin
        addrs[i] = addrs[4];
      end else begin
        addrs[i] = (`SPI_ADDR_BITS)'($urandom % `SPI_MEM_DEPTH);
      end
      spiWrite(addrs[i], ByteBits'($urandom));
    end
    // reverse order, repeated addresses must show the last write.
    for (int i = 15; i >= 0; i--) begin
      readAndCompare(addrs[i]);
    end
    reportTest("randomStress", errorsBefore);
  endtask

  task automatic testAbort();
    int errorsBefore;
    logic [ByteBits-1:0] unused;
    errorsBefore = errorCount;
    spiWrite(7'h2C, 8'h3C);
    runFrame({7'h2C, 1'b0, 8'hC3}, ByteBits + 4, 1'b0, NoGlitch, unused);
    readAndCompare(7'h2C);
    spiWrite(7'h2C, 8'h5A);
    readAndCompare(7'h2C);
    reportTest("abort", errorsBefore);
  endtask

  task automatic testMisoEnable();
    int errorsBefore;
    errorsBefore = errorCount;
    assert (enableAfterReset === 1'b0)
    else begin
      $display("ERROR at %0t ns: misoBufferEnable was %b after reset, expected 0",
               $time, enableAfterReset);
      errorCount++;
    end
    spiWrite(7'h11, 8'h96);
    readAndCompare(7'h11);
    reportTest("misoEnable", errorsBefore);
  endtask

  task automatic testGlitchFilter();
    int errorsBefore;
    logic [ByteBits-1:0] unused;
    errorsBefore = errorCount;
    runFrame({7'h40, 1'b0, 8'hB4}, FrameBits, 1'b0, ByteBits + 2, unused);
    model[7'h40] = 8'hB4;
    readAndCompare(7'h40);
    reportTest("glitchFilter", errorsBefore);
  endtask

  initial begin
    void'($urandom(32'h9c8e_12f8));
    errorCount = 0;
    testCount = 0;
    failedTests = 0;
    rstN = 1'b0;
    csN = 1'b1;
    sclk = 1'b0;
    mosi = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rstN = 1'b1;
    waitClocks(2);
    enableAfterReset = misoBufferEnable;
    testWriteReadBack();
    testRandomStress();
    testAbort();
    testMisoEnable();
    testGlitchFilter();
    $display("summary: %0d tests run, %0d failed, %0d check errors",
             testCount, failedTests, errorCount);
    if (failedTests == 0 && errorCount == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+logic
logic/spiMemPkg.sv
logic/inputConditioner.sv
logic/spiFsm.sv
logic/shiftRegister.sv
logic/dataMemory.sv
logic/spiMemory.sv
sim/spiMemoryTb.sv
